// ==== include/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath widths
`define MIPS_WORD_W         32
`define MIPS_REG_ADDR_W     5
`define MIPS_NUM_REGS       32

// instruction memory
`define MIPS_IMEM_ADDR_W    8
`define MIPS_IMEM_DEPTH     256

// instruction fields
`define MIPS_OP_W           6
`define MIPS_FN_W           6
`define MIPS_IMM_W          16

// opcodes
`define MIPS_OP_RTYPE       6'h00
`define MIPS_OP_ADDI        6'h08

// funct codes of the R-type group
`define MIPS_FN_ADDU        6'h21
`define MIPS_FN_SUBU        6'h23
`define MIPS_FN_AND         6'h24
`define MIPS_FN_OR          6'h25
`define MIPS_FN_XOR         6'h26
`define MIPS_FN_SLT         6'h2a

`define MIPS_HALT_WORD      32'hffff_ffff

`endif

// ==== hdl/mips_pkg.sv ====
`include "mips_cfg.svh"

package mips_pkg;

    // data value or instruction word
    typedef logic [`MIPS_WORD_W-1:0] word_t;

    // register number
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    // instruction word address, doubles as the pc
    typedef logic [`MIPS_IMEM_ADDR_W-1:0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        word_t instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     rs_val;
        word_t     rt_val;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      imm_sel;
        word_t     imm;
        logic      reg_write;
        reg_addr_t dst;
        logic      halt;
    } id_ex_t;

    // one register write, also the top-level write stream
    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
        word_t     data;
    } reg_write_t;

endpackage

// ==== hdl/mips_fetch.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_fetch (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic                 i_run,
    input  logic                 i_imem_write,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    input  logic                 i_halt_seen,
    output mips_pkg::if_id_t     o_if_id
);

    mips_pkg::word_t      imem [`MIPS_IMEM_DEPTH];
    mips_pkg::imem_addr_t pc;
    logic                 issue;

    // pc stops as soon as decode has seen the halt word
    assign issue = i_run && !i_halt_seen;

    // program load port, only open while the core is idle
    always_ff @(posedge clk) begin
        if (!i_run && i_imem_write) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (issue) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch to decode register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_if_id.valid <= 1'b0;
        end else begin
            o_if_id.valid <= issue;
            o_if_id.instr <= imem[pc];
        end
    end

endmodule

// ==== hdl/mips_decode.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_decode (
    input  logic                 clk,
    input  logic                 i_reset,
    input  mips_pkg::if_id_t     i_if_id,
    input  mips_pkg::reg_write_t i_wb,
    output mips_pkg::id_ex_t     o_id_ex,
    output logic                 o_halt_seen
);

    mips_pkg::word_t        regs [`MIPS_NUM_REGS];
    logic [`MIPS_OP_W-1:0]  opcode;
    logic [`MIPS_FN_W-1:0]  funct;
    logic [`MIPS_IMM_W-1:0] imm;
    mips_pkg::reg_addr_t    rs;
    mips_pkg::reg_addr_t    rt;
    mips_pkg::reg_addr_t    rd;
    mips_pkg::word_t        rs_val;
    mips_pkg::word_t        rt_val;
    logic                   is_halt;
    mips_pkg::id_ex_t       id_ex_d;

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign imm    = i_if_id.instr[15:0];

    assign is_halt = i_if_id.valid && (i_if_id.instr == `MIPS_HALT_WORD);

    // r0 is hardwired, a write in flight shows through to the read ports
    assign rs_val = (rs == '0) ? '0 :
                    (i_wb.valid && i_wb.dst == rs) ? i_wb.data : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (i_wb.valid && i_wb.dst == rt) ? i_wb.data : regs[rt];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && i_wb.dst != '0) begin
            regs[i_wb.dst] <= i_wb.data;
        end
    end

    always_comb begin
        id_ex_d           = '0;
        id_ex_d.alu_op    = mips_pkg::ALU_ADD;
        id_ex_d.rs        = rs;
        id_ex_d.rt        = rt;
        id_ex_d.rs_val    = rs_val;
        id_ex_d.rt_val    = rt_val;
        id_ex_d.imm       = {{(`MIPS_WORD_W - `MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};
        // everything behind a halt is squashed
        if (i_if_id.valid && !o_halt_seen) begin
            if (is_halt) begin
                id_ex_d.valid = 1'b1;
                id_ex_d.halt  = 1'b1;
            end else if (opcode == `MIPS_OP_RTYPE) begin
                id_ex_d.valid     = 1'b1;
                id_ex_d.dst       = rd;
                id_ex_d.reg_write = (rd != '0);
                case (funct)
                    `MIPS_FN_ADDU: id_ex_d.alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: id_ex_d.alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  id_ex_d.alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   id_ex_d.alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_XOR:  id_ex_d.alu_op = mips_pkg::ALU_XOR;
                    `MIPS_FN_SLT:  id_ex_d.alu_op = mips_pkg::ALU_SLT;
                    default: begin
                        id_ex_d.valid     = 1'b0;
                        id_ex_d.reg_write = 1'b0;
                    end
                endcase
            end else if (opcode == `MIPS_OP_ADDI) begin
                id_ex_d.valid     = 1'b1;
                id_ex_d.imm_sel   = 1'b1;
                id_ex_d.dst       = rt;
                id_ex_d.reg_write = (rt != '0);
            end
        end
    end

    // halt flag stays set until reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_halt_seen <= 1'b0;
        end else if (is_halt) begin
            o_halt_seen <= 1'b1;
        end
    end

    // decode to execute register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_id_ex.valid     <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
            o_id_ex.halt      <= 1'b0;
        end else begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

// ==== hdl/mips_execute.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_execute (
    input  logic                 clk,
    input  logic                 i_reset,
    input  mips_pkg::id_ex_t     i_id_ex,
    output mips_pkg::reg_write_t o_ex_wb,
    output logic                 o_halt
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t fwd_b;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_res;
    logic            fwd_a_hit;
    logic            fwd_b_hit;
    logic            lt;

    // forward from the previous instruction only
    // older results come through the decode write-through
    assign fwd_a_hit = o_ex_wb.valid && (o_ex_wb.dst == i_id_ex.rs);
    assign fwd_b_hit = o_ex_wb.valid && (o_ex_wb.dst == i_id_ex.rt);

    assign op_a  = fwd_a_hit ? o_ex_wb.data : i_id_ex.rs_val;
    assign fwd_b = fwd_b_hit ? o_ex_wb.data : i_id_ex.rt_val;

    // addi takes the sign-extended immediate
    assign op_b = i_id_ex.imm_sel ? i_id_ex.imm : fwd_b;

    // signed compare for slt
    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            mips_pkg::ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            mips_pkg::ALU_AND: begin
                alu_res = op_a & op_b;
            end
            mips_pkg::ALU_OR: begin
                alu_res = op_a | op_b;
            end
            mips_pkg::ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            mips_pkg::ALU_SLT: begin
                alu_res = {{(`MIPS_WORD_W - 1){1'b0}}, lt};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // execute to result register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ex_wb.valid <= 1'b0;
            o_halt        <= 1'b0;
        end else begin
            o_ex_wb.valid <= i_id_ex.valid && i_id_ex.reg_write;
            o_ex_wb.dst   <= i_id_ex.dst;
            o_ex_wb.data  <= alu_res;
            o_halt        <= i_id_ex.valid && i_id_ex.halt;
        end
    end

endmodule

// ==== hdl/mips_result.sv ====
`timescale 1ns/1ps

module mips_result (
    input  logic                 clk,
    input  logic                 i_reset,
    input  mips_pkg::reg_write_t i_ex_wb,
    input  logic                 i_halt,
    output mips_pkg::reg_write_t o_wb,
    output logic                 o_halted
);

    // same write goes to the register file and out of the core
    assign o_wb = i_ex_wb;

    // halted until the next reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_halted <= 1'b0;
        end else if (i_halt) begin
            o_halted <= 1'b1;
        end
    end

endmodule

// ==== hdl/mips_top.sv ====
`timescale 1ns/1ps

module mips_top (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic                 i_run,
    input  logic                 i_imem_write,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    output mips_pkg::reg_write_t o_wb,
    output logic                 o_halted
);

    mips_pkg::if_id_t     if_id;
    mips_pkg::id_ex_t     id_ex;
    mips_pkg::reg_write_t ex_wb;
    logic                 halt_seen;
    logic                 ex_halt;

    mips_fetch u_fetch (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_imem_write (i_imem_write),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .i_halt_seen  (halt_seen),
        .o_if_id      (if_id)
    );

    // write port fed back from the result stage
    mips_decode u_decode (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_if_id     (if_id),
        .i_wb        (o_wb),
        .o_id_ex     (id_ex),
        .o_halt_seen (halt_seen)
    );

    mips_execute u_execute (
        .clk     (clk),
        .i_reset (i_reset),
        .i_id_ex (id_ex),
        .o_ex_wb (ex_wb),
        .o_halt  (ex_halt)
    );

    mips_result u_result (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_ex_wb  (ex_wb),
        .i_halt   (ex_halt),
        .o_wb     (o_wb),
        .o_halted (o_halted)
    );

endmodule

// ==== verif/mips_tb.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_tb;

    localparam int PROG_LEN       = 200;
    localparam int PROG_WORDS     = PROG_LEN + 1;
    localparam int RESET_CYCLES   = 2;
    localparam int PIPE_DEPTH     = 4;
    localparam int DRAIN_CYCLES   = 8;
    // reset, one load cycle per word, one issue cycle per word, pipeline, drain, margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * PROG_WORDS + PIPE_DEPTH
                                    + DRAIN_CYCLES + 16;
    localparam logic [31:0] SEED  = 32'd9038;

    logic                 clk;
    logic                 i_reset;
    logic                 i_run;
    logic                 i_imem_write;
    mips_pkg::imem_addr_t i_imem_addr;
    mips_pkg::word_t      i_imem_data;
    mips_pkg::reg_write_t wb;
    logic                 halted;

    mips_pkg::word_t     prog [PROG_WORDS];
    logic                slot_wr [PROG_LEN];
    mips_pkg::reg_addr_t slot_dst [PROG_LEN];
    mips_pkg::word_t     slot_data [PROG_LEN];
    mips_pkg::word_t     model_regs [8];
    logic [31:0]         rng;
    int                  exp_count;

    logic                reset_seen  = 1'b0;
    int                  run_edges   = 0;
    int                  wb_count    = 0;
    int                  cycle_count = 0;
    logic                due_valid;
    mips_pkg::reg_addr_t due_dst;
    mips_pkg::word_t     due_data;
    logic                halt_due;

    mips_top u_dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_imem_write (i_imem_write),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_wb         (wb),
        .o_halted     (halted)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // kinds 0 to 5 are the R-type group, 6 is addi
    function automatic logic [5:0] funct_of(input int kind);
        case (kind)
            0:       return `MIPS_FN_ADDU;
            1:       return `MIPS_FN_SUBU;
            2:       return `MIPS_FN_AND;
            3:       return `MIPS_FN_OR;
            4:       return `MIPS_FN_XOR;
            default: return `MIPS_FN_SLT;
        endcase
    endfunction

    function automatic mips_pkg::word_t alu_model(input int kind, input mips_pkg::word_t a,
                                                   input mips_pkg::word_t b);
        case (kind)
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    // random program plus the in-order register model
    task automatic build_program();
        logic [31:0]         r1;
        logic [31:0]         r2;
        int                  kind;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t dst;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     res;
        rng = SEED;
        exp_count = 0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rng = xorshift(rng);
            r1 = rng;
            rng = xorshift(rng);
            r2 = rng;
            kind = (i % 8 == 2) ? int'(r1 % 32'd6) : int'(r1 % 32'd7);
            rs = {2'b00, r1[18:16]};
            rt = {2'b00, r1[21:19]};
            dst = {2'b00, r1[24:22]};
            // make sure each group has a producer for the next two
            if (i % 8 == 0 && dst == '0) begin
                dst = 5'd7;
            end
            // back-to-back and distance-two dependences
            if (i % 8 == 1) begin
                rs = slot_dst[i-1];
            end
            if (i % 8 == 2) begin
                rt = slot_dst[i-2];
            end
            a = model_regs[rs[2:0]];
            if (kind == 6) begin
                b = {{16{r2[15]}}, r2[15:0]};
                prog[i] = {`MIPS_OP_ADDI, rs, dst, r2[15:0]};
            end else begin
                b = model_regs[rt[2:0]];
                prog[i] = {`MIPS_OP_RTYPE, rs, rt, dst, 5'b00000, funct_of(kind)};
            end
            res = alu_model(kind, a, b);
            slot_dst[i] = dst;
            slot_data[i] = res;
            slot_wr[i] = (dst != '0);
            if (dst != '0) begin
                model_regs[dst[2:0]] = res;
                exp_count++;
            end
        end
        prog[PROG_LEN] = `MIPS_HALT_WORD;
    endtask

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (i_reset) begin
            reset_seen <= 1'b1;
        end
        if (i_run) begin
            run_edges <= run_edges + 1;
        end
        if (wb.valid === 1'b1) begin
            wb_count <= wb_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    // instruction k shows up on o_wb once run has been high for k+3 edges
    always_comb begin
        int slot;
        slot = run_edges - 3;
        due_valid = 1'b0;
        due_dst = '0;
        due_data = '0;
        if (slot >= 0 && slot < PROG_LEN) begin
            due_valid = slot_wr[slot];
            due_dst = slot_dst[slot];
            due_data = slot_data[slot];
        end
    end

    assign halt_due = (run_edges >= PROG_LEN + 4);

    a_wb_valid: assert property (@(posedge clk) reset_seen |-> (wb.valid == due_valid))
        else begin
            $display("ERR %0t o_wb.valid expected %0b got %0b", $time,
                     $sampled(due_valid), $sampled(wb.valid));
            stop_on_error();
        end

    a_wb_dst: assert property (@(posedge clk) wb.valid |-> (wb.dst == due_dst))
        else begin
            $display("ERR %0t o_wb.dst expected %0d got %0d", $time,
                     $sampled(due_dst), $sampled(wb.dst));
            stop_on_error();
        end

    a_wb_data: assert property (@(posedge clk) wb.valid |-> (wb.data == due_data))
        else begin
            $display("ERR %0t o_wb.data expected %h got %h", $time,
                     $sampled(due_data), $sampled(wb.data));
            stop_on_error();
        end

    a_wb_r0: assert property (@(posedge clk) wb.valid |-> (wb.dst != '0))
        else begin
            $display("ERR %0t o_wb.dst expected nonzero got %0d", $time, $sampled(wb.dst));
            stop_on_error();
        end

    a_halted: assert property (@(posedge clk) reset_seen |-> (halted == halt_due))
        else begin
            $display("ERR %0t o_halted expected %0b got %0b", $time,
                     $sampled(halt_due), $sampled(halted));
            stop_on_error();
        end

    a_drained: assert property (@(posedge clk) halted |-> (wb_count == exp_count))
        else begin
            $display("ERR %0t o_wb write count expected %0d got %0d", $time,
                     exp_count, $sampled(wb_count));
            stop_on_error();
        end

    initial begin
        clk = 1'b0;
        i_reset = 1'b1;
        i_run = 1'b0;
        i_imem_write = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        for (int a = 0; a < PROG_WORDS; a++) begin
            i_imem_write <= 1'b1;
            i_imem_addr <= mips_pkg::imem_addr_t'(a);
            i_imem_data <= prog[a];
            @(posedge clk);
        end
        i_imem_write <= 1'b0;
        i_run <= 1'b1;
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        // quiet period after the halt
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (wb_count == exp_count) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERR %0t o_wb write count expected %0d got %0d", $time,
                     exp_count, wb_count);
            stop_on_error();
        end
    end

endmodule

// ==== all.f ====
+incdir+include
hdl/mips_pkg.sv
hdl/mips_fetch.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_result.sv
hdl/mips_top.sv
verif/mips_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS core testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module mips_tb \
    -o mips_sim

# the simulator exit status is not trusted, the log decides
./obj_dir/mips_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "FAIL: see errors above" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -qF "PASS: all tests" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
